//--- rtl/wbPkg.sv
package wbPkg;

    // --------------------
    // Data path
    // --------------------
    localparam int dataWidth   = 64;          // One DQ beat
    localparam int userWidth   = 1;           // Frontend user tag
    localparam int idWidth     = 4;           // Transaction ID

    // --------------------
    // Burst geometry
    // --------------------
    // One strobe bit per beat, so the mask is burstLength wide
    localparam int burstLength = 8;           // Beats per burst

    // --------------------
    // Buffer sizing
    // --------------------
    localparam int bufferDepth = 8;           // Directory entries, one burst each

    // Derived sizes
    localparam int slotWidth    = $clog2(bufferDepth);        // Directory index
    localparam int beatWidth    = $clog2(burstLength);        // Beat index in a burst
    localparam int memAddrWidth = slotWidth + beatWidth;      // {slot, beat} word address

    // Window count must reach bufferDepth itself, hence the +1
    localparam int windowWidth  = $clog2(bufferDepth + 1);

endpackage

//--- rtl/wbFrontIntake.sv
`timescale 1ns/100ps

module wbFrontIntake (
    input  logic                            clk,
    input  logic                            rst,
    // Frontend beat
    input  logic [wbPkg::dataWidth-1:0]     writeData,
    input  logic [wbPkg::userWidth-1:0]     writeDataUser,
    input  logic [wbPkg::idWidth-1:0]       writeDataID,
    input  logic [wbPkg::burstLength-1:0]   writeDataStrb,
    input  logic                            writeDataLast,
    input  logic                            writeDataValid,
    input  logic                            writeDataACKReady,
    input  logic                            writeModeACK,    // PHY finished one write
    // From directory
    input  logic [wbPkg::slotWidth-1:0]     freeSlot,
    input  logic                            dirFull,
    // Frontend side outputs
    output logic                            writeBufferFull,
    output logic                            writeDataACKValid,
    output logic [wbPkg::userWidth-1:0]     writeDataACKUser,
    output logic [wbPkg::idWidth-1:0]       writeDataACKID,
    output logic [wbPkg::windowWidth-1:0]   writeRequestWindow,
    // To directory
    output logic                            allocValid,
    output logic [wbPkg::slotWidth-1:0]     allocSlot,
    output logic [wbPkg::idWidth-1:0]       allocID,
    output logic [wbPkg::userWidth-1:0]     allocUser,
    output logic [wbPkg::burstLength-1:0]   allocStrb,
    // To data store
    output logic                            writeEnable,
    output logic [wbPkg::slotWidth-1:0]     writeSlot,
    output logic [wbPkg::beatWidth-1:0]     writeBeat,
    output logic [wbPkg::dataWidth-1:0]     storeData
);

    logic                          accept;      // Beat taken this cycle
    logic                          firstBeat;   // Beat counter at zero
    logic [wbPkg::beatWidth-1:0]   beatCnt;     // Beat index within current burst
    logic [wbPkg::slotWidth-1:0]   slotHold;    // Slot latched at first beat

    // --------------------
    // Accept and slot select
    // --------------------
    assign writeBufferFull = dirFull;
    assign accept          = writeDataValid && !dirFull;
    assign firstBeat       = (beatCnt == '0);
    // First beat takes the live free slot, later beats stay on the held one
    assign writeSlot       = firstBeat ? freeSlot : slotHold;

    assign writeEnable = accept;
    assign writeBeat   = beatCnt;
    assign storeData   = writeData;

    // Directory entry is created on the last beat
    assign allocValid = accept && writeDataLast;
    assign allocSlot  = writeSlot;
    assign allocID    = writeDataID;
    assign allocUser  = writeDataUser;
    assign allocStrb  = writeDataStrb;

    // Write response, same cycle as the accepted last beat
    assign writeDataACKValid = accept && writeDataLast && writeDataACKReady;
    assign writeDataACKID    = writeDataID;      // Echo of the beat's own fields
    assign writeDataACKUser  = writeDataUser;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beatCnt  <= '0;
            slotHold <= '0;
        end else if (accept) begin
            if (firstBeat) begin
                slotHold <= freeSlot;    // Pin the burst to this slot
            end
            if (writeDataLast) begin
                beatCnt <= '0;           // Next beat opens a new burst
            end else begin
                beatCnt <= beatCnt + 1'b1;
            end
        end
    end

    // --------------------
    // Outstanding write window
    // --------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            writeRequestWindow <= '0;
        end else begin
            case ({allocValid, writeModeACK})
                2'b10:   writeRequestWindow <= writeRequestWindow + 1'b1;  // New burst
                2'b01:   writeRequestWindow <= writeRequestWindow - 1'b1;  // PHY done
                default: writeRequestWindow <= writeRequestWindow;         // Both or none
            endcase
        end
    end

endmodule

//--- rtl/wbDirectory.sv
`timescale 1ns/100ps

module wbDirectory (
    input  logic                            clk,
    input  logic                            rst,
    // Allocation from intake
    input  logic                            allocValid,
    input  logic [wbPkg::slotWidth-1:0]     allocSlot,
    input  logic [wbPkg::idWidth-1:0]       allocID,
    input  logic [wbPkg::userWidth-1:0]     allocUser,
    input  logic [wbPkg::burstLength-1:0]   allocStrb,
    // Issue acknowledge from scheduler
    input  logic [wbPkg::idWidth-1:0]       writeBufferAllocID,
    input  logic [wbPkg::userWidth-1:0]     writeBufferAllocUser,
    input  logic                            writeBufferAllocValid,
    // Release from streamer
    input  logic [wbPkg::slotWidth-1:0]     readSlot,
    input  logic                            releaseValid,
    // Status
    output logic [wbPkg::slotWidth-1:0]     freeSlot,
    output logic                            dirFull,
    output logic [wbPkg::bufferDepth-1:0]   issuedVector,
    output logic [wbPkg::burstLength-1:0]   readStrbMask
);

    // Per-entry state
    logic [wbPkg::bufferDepth-1:0] validVector;                   // Entry holds a burst
    logic [wbPkg::idWidth-1:0]     entryID   [wbPkg::bufferDepth];
    logic [wbPkg::userWidth-1:0]   entryUser [wbPkg::bufferDepth];
    logic [wbPkg::burstLength-1:0] entryStrb [wbPkg::bufferDepth]; // Per-beat strobes

    // Issue match
    logic [wbPkg::bufferDepth-1:0] issueCand;   // Valid, unissued, ID and user equal
    logic [wbPkg::slotWidth-1:0]   issueSlot;
    logic                          issueHit;

    // --------------------
    // Free slot search
    // --------------------
    // Walk downwards so the lowest free index wins
    always_comb begin
        freeSlot = '0;
        for (int i = wbPkg::bufferDepth - 1; i >= 0; i--) begin
            if (!validVector[i]) begin
                freeSlot = wbPkg::slotWidth'(i);
            end
        end
    end

    assign dirFull = &validVector;      // No free entry left

    // --------------------
    // Issue matching
    // --------------------
    always_comb begin
        for (int i = 0; i < wbPkg::bufferDepth; i++) begin
            issueCand[i] = validVector[i] && !issuedVector[i]
                           && (entryID[i] == writeBufferAllocID)
                           && (entryUser[i] == writeBufferAllocUser);
        end
    end

    // Lowest matching index, duplicates go out oldest slot first
    always_comb begin
        issueSlot = '0;
        for (int i = wbPkg::bufferDepth - 1; i >= 0; i--) begin
            if (issueCand[i]) begin
                issueSlot = wbPkg::slotWidth'(i);
            end
        end
    end

    assign issueHit = |issueCand;       // No match means the ack is dropped

    // Strobe mask of the entry being streamed
    assign readStrbMask = entryStrb[readSlot];

    // --------------------
    // Valid and issued bits
    // --------------------
    // Alloc, issue and release always hit different slots
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            validVector  <= '0;
            issuedVector <= '0;
        end else begin
            if (allocValid) begin
                validVector[allocSlot]  <= 1'b1;
                issuedVector[allocSlot] <= 1'b0;
            end
            if (writeBufferAllocValid && issueHit) begin
                issuedVector[issueSlot] <= 1'b1;        // Ready to stream
            end
            if (releaseValid) begin
                validVector[readSlot]  <= 1'b0;         // Last beat read
                issuedVector[readSlot] <= 1'b0;
            end
        end
    end

    // Entry payload, written once per burst
    always_ff @(posedge clk) begin
        if (allocValid) begin
            entryID[allocSlot]   <= allocID;
            entryUser[allocSlot] <= allocUser;
            entryStrb[allocSlot] <= allocStrb;
        end
    end

endmodule

//--- rtl/wbDataStore.sv
`timescale 1ns/100ps

module wbDataStore (
    input  logic                          clk,
    // Write port, intake side
    input  logic                          writeEnable,
    input  logic [wbPkg::slotWidth-1:0]   writeSlot,
    input  logic [wbPkg::beatWidth-1:0]   writeBeat,
    input  logic [wbPkg::dataWidth-1:0]   writeData,
    // Read port, PHY side
    input  logic                          readEnable,
    input  logic [wbPkg::slotWidth-1:0]   readSlot,
    input  logic [wbPkg::beatWidth-1:0]   readBeat,
    output logic [wbPkg::dataWidth-1:0]   readData
);

    localparam int memWords = wbPkg::bufferDepth * wbPkg::burstLength;

    // --------------------
    // Burst memory
    // --------------------
    // One row of burstLength words per directory slot
    logic [wbPkg::dataWidth-1:0]    mem [memWords];
    logic [wbPkg::memAddrWidth-1:0] writeAddr;
    logic [wbPkg::memAddrWidth-1:0] readAddr;

    assign writeAddr = {writeSlot, writeBeat};   // Slot selects row, beat selects word
    assign readAddr  = {readSlot, readBeat};

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeAddr] <= writeData;
        end
    end

    // Registered read, data one cycle after readEnable
    always_ff @(posedge clk) begin
        if (readEnable) begin
            readData <= mem[readAddr];   // Holds last beat otherwise
        end
    end

endmodule

//--- rtl/wbBurstStreamer.sv
`timescale 1ns/100ps

module wbBurstStreamer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [wbPkg::bufferDepth-1:0]   issuedVector,
    input  logic [wbPkg::burstLength-1:0]   readStrbMask,    // Mask of readSlot
    input  logic                            phyWriteModeFIFOReady,
    // To data store and directory
    output logic                            readEnable,
    output logic [wbPkg::slotWidth-1:0]     readSlot,
    output logic [wbPkg::beatWidth-1:0]     readBeat,
    output logic                            releaseValid,
    // To PHY, aligned with store read data
    output logic                            readDataValid,
    output logic                            readDataLast,
    output logic                            readDataStrb
);

    logic                          anyIssued;   // Some entry waits for the PHY
    logic                          locked;      // Mid-burst on lockSlot
    logic [wbPkg::slotWidth-1:0]   lockSlot;
    logic [wbPkg::slotWidth-1:0]   pickSlot;    // Lowest issued entry
    logic [wbPkg::beatWidth-1:0]   beatCnt;
    logic                          lastBeat;

    // --------------------
    // Entry select
    // --------------------
    always_comb begin
        pickSlot = '0;
        for (int i = wbPkg::bufferDepth - 1; i >= 0; i--) begin
            if (issuedVector[i]) begin
                pickSlot = wbPkg::slotWidth'(i);
            end
        end
    end

    assign anyIssued = |issuedVector;
    // Stay on the locked entry even if a lower one gets issued
    assign readSlot  = locked ? lockSlot : pickSlot;
    assign readBeat  = beatCnt;

    assign lastBeat     = (beatCnt == wbPkg::beatWidth'(wbPkg::burstLength - 1));
    assign readEnable   = anyIssued && phyWriteModeFIFOReady;   // One beat per ready cycle
    assign releaseValid = readEnable && lastBeat;               // Frees the entry

    // --------------------
    // Beat counter and lock
    // --------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            locked   <= 1'b0;
            lockSlot <= '0;
            beatCnt  <= '0;
        end else if (readEnable) begin
            if (lastBeat) begin
                locked  <= 1'b0;         // Free to pick again
                beatCnt <= '0;
            end else begin
                locked   <= 1'b1;
                lockSlot <= readSlot;
                beatCnt  <= beatCnt + 1'b1;
            end
        end
    end

    // Output flags, one cycle behind the read like the store data
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            readDataValid <= 1'b0;
            readDataLast  <= 1'b0;
            readDataStrb  <= 1'b0;
        end else begin
            readDataValid <= readEnable;
            readDataLast  <= readEnable && lastBeat;
            readDataStrb  <= readStrbMask[beatCnt];     // Strobe bit of this beat
        end
    end

endmodule

//--- rtl/writeBufferCtrl.sv
`timescale 1ns/100ps

module writeBufferCtrl (
    input  logic                            clk,
    input  logic                            rst,
    // --------------------
    // Frontend
    // --------------------
    input  logic [wbPkg::dataWidth-1:0]     writeData,
    input  logic [wbPkg::userWidth-1:0]     writeDataUser,
    input  logic [wbPkg::idWidth-1:0]       writeDataID,
    input  logic [wbPkg::burstLength-1:0]   writeDataStrb,
    input  logic                            writeDataLast,
    input  logic                            writeDataValid,
    input  logic                            writeDataACKReady,
    output logic                            writeDataACKValid,
    output logic [wbPkg::userWidth-1:0]     writeDataACKUser,
    output logic [wbPkg::idWidth-1:0]       writeDataACKID,
    output logic                            writeBufferFull,
    // --------------------
    // Scheduler
    // --------------------
    input  logic [wbPkg::idWidth-1:0]       writeBufferAllocID,
    input  logic [wbPkg::userWidth-1:0]     writeBufferAllocUser,
    input  logic                            writeBufferAllocValid,   // Issue ack
    output logic [wbPkg::windowWidth-1:0]   writeRequestWindow,
    // --------------------
    // PHY
    // --------------------
    input  logic                            phyWriteModeFIFOReady,
    input  logic                            writeModeACK,
    output logic [wbPkg::dataWidth-1:0]     readData,
    output logic                            readDataLast,
    output logic                            readDataValid,
    output logic                            readDataStrb
);

    // Intake to directory
    logic                          allocValid;
    logic [wbPkg::slotWidth-1:0]   allocSlot;
    logic [wbPkg::idWidth-1:0]     allocID;
    logic [wbPkg::userWidth-1:0]   allocUser;
    logic [wbPkg::burstLength-1:0] allocStrb;
    // Intake to data store
    logic                          writeEnable;
    logic [wbPkg::slotWidth-1:0]   writeSlot;
    logic [wbPkg::beatWidth-1:0]   writeBeat;
    logic [wbPkg::dataWidth-1:0]   storeData;
    // Directory status
    logic [wbPkg::slotWidth-1:0]   freeSlot;
    logic                          dirFull;
    logic [wbPkg::bufferDepth-1:0] issuedVector;
    logic [wbPkg::burstLength-1:0] readStrbMask;
    // Streamer controls
    logic                          readEnable;
    logic [wbPkg::slotWidth-1:0]   readSlot;
    logic [wbPkg::beatWidth-1:0]   readBeat;
    logic                          releaseValid;

    wbFrontIntake wbFrontIntake_inst (
        .clk, .rst, .writeData, .writeDataUser, .writeDataID, .writeDataStrb,
        .writeDataLast, .writeDataValid, .writeDataACKReady, .writeModeACK,
        .freeSlot, .dirFull, .writeBufferFull, .writeDataACKValid, .writeDataACKUser,
        .writeDataACKID, .writeRequestWindow, .allocValid, .allocSlot, .allocID,
        .allocUser, .allocStrb, .writeEnable, .writeSlot, .writeBeat, .storeData
    );

    wbDirectory wbDirectory_inst (
        .clk, .rst, .allocValid, .allocSlot, .allocID, .allocUser, .allocStrb,
        .writeBufferAllocID, .writeBufferAllocUser, .writeBufferAllocValid,
        .readSlot, .releaseValid, .freeSlot, .dirFull, .issuedVector, .readStrbMask
    );

    // Store write data comes from the intake, not straight from the port
    wbDataStore wbDataStore_inst (
        .clk, .writeEnable, .writeSlot, .writeBeat, .writeData(storeData),
        .readEnable, .readSlot, .readBeat, .readData
    );

    wbBurstStreamer wbBurstStreamer_inst (
        .clk, .rst, .issuedVector, .readStrbMask, .phyWriteModeFIFOReady,
        .readEnable, .readSlot, .readBeat, .releaseValid,
        .readDataValid, .readDataLast, .readDataStrb
    );

endmodule

//--- verif/writeBufferCtrl_sva.sv
`timescale 1ns/100ps

module writeBufferCtrl_sva (
    input logic clk,
    input logic rst,
    input logic writeDataLast,
    input logic writeDataACKValid,
    input logic writeBufferFull,
    input logic readDataValid,
    input logic readDataLast
);

    // --------------------
    // Port rules
    // --------------------
    lastNeedsValid: assert property (@(posedge clk) disable iff (!rst)
        readDataLast |-> readDataValid)                   // Last rides on a valid beat
        else $error("readDataLast high without readDataValid");

    // Buffer comes out of reset empty
    emptyAfterReset: assert property (@(posedge clk) $rose(rst) |-> !writeBufferFull)
        else $error("writeBufferFull high in the first cycle after reset");

    ackOnLastBeat: assert property (@(posedge clk) disable iff (!rst)
        writeDataACKValid |-> writeDataLast)              // Response closes a burst
        else $error("writeDataACKValid without writeDataLast");

endmodule

bind writeBufferCtrl writeBufferCtrl_sva writeBufferCtrl_sva_inst (
    .clk(clk),
    .rst(rst),
    .writeDataLast(writeDataLast),
    .writeDataACKValid(writeDataACKValid),
    .writeBufferFull(writeBufferFull),
    .readDataValid(readDataValid),
    .readDataLast(readDataLast)
);

//--- verif/tb_writeBufferCtrl.sv
`timescale 1ns/100ps

module tb_writeBufferCtrl;

    localparam int clkPeriod     = 4;
    localparam int seed          = 36074;
    localparam int rows          = 8;                  // One row per directory entry
    localparam int timeoutCycles = rows * (wbPkg::burstLength + 20) * 8;

    logic                            clk;
    logic                            rst;
    logic [wbPkg::dataWidth-1:0]     writeData;
    logic [wbPkg::userWidth-1:0]     writeDataUser;
    logic [wbPkg::idWidth-1:0]       writeDataID;
    logic [wbPkg::burstLength-1:0]   writeDataStrb;
    logic                            writeDataLast;
    logic                            writeDataValid;
    logic                            writeDataACKReady;
    logic                            writeDataACKValid;
    logic                            writeBufferFull;
    logic [wbPkg::userWidth-1:0]     writeDataACKUser;
    logic [wbPkg::idWidth-1:0]       writeDataACKID;
    logic [wbPkg::idWidth-1:0]       writeBufferAllocID;
    logic [wbPkg::userWidth-1:0]     writeBufferAllocUser;
    logic                            writeBufferAllocValid;
    logic [wbPkg::windowWidth-1:0]   writeRequestWindow;
    logic                            phyWriteModeFIFOReady;
    logic                            writeModeACK;
    logic [wbPkg::dataWidth-1:0]     readData;
    logic                            readDataLast;
    logic                            readDataValid;
    logic                            readDataStrb;

    writeBufferCtrl writeBufferCtrl_inst (.*);

    // --------------------
    // Stimulus table
    // --------------------
    // Rows 1 and 4 share ID and user, row 6 shares the ID only
    logic [wbPkg::idWidth-1:0]     rowId   [rows] = '{4'h3, 4'h9, 4'h5, 4'hC,
                                                      4'h9, 4'h1, 4'h9, 4'h7};
    logic [wbPkg::userWidth-1:0]   rowUser [rows] = '{1'b0, 1'b1, 1'b0, 1'b1,
                                                      1'b1, 1'b0, 1'b0, 1'b1};
    logic [wbPkg::burstLength-1:0] rowStrb [rows] = '{8'hA5, 8'hFF, 8'h3C, 8'h81,
                                                      8'h0F, 8'h5A, 8'hF0, 8'h01};
    logic [wbPkg::dataWidth-1:0]   rowBase [rows] = '{
        64'h1111_2222_3333_0000, 64'h2468_ACE0_1357_9B00, 64'hDEAD_BEEF_0000_0100,
        64'h0F0F_F0F0_5555_AA00, 64'h7654_3210_FEDC_BA00, 64'h8000_0000_0000_0800,
        64'hCAFE_F00D_1234_5600, 64'h0000_FFFF_0000_FF00};
    int rowDelay [rows] = '{0, 3, 1, 5, 2, 0, 4, 1};         // Idle cycles before the issue
    int rowDuty  [rows] = '{100, 60, 40, 80, 50, 100, 70, 45}; // PHY ready, percent

    // Issue order, ID-only twin ahead of the lower 9/1 entries, others out of slot order
    int streamOrder [rows] = '{6, 1, 3, 4, 0, 7, 2, 5};

    // Scoreboard model of the directory
    bit                            slotUsed [wbPkg::bufferDepth];
    int                            slotRow  [wbPkg::bufferDepth];  // Table row held per slot
    logic [wbPkg::windowWidth-1:0] expWindow;

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(timeoutCycles * clkPeriod);
        $display("Timeout: run still busy after %0d cycles", timeoutCycles);
        stopRun();
    end

    // --------------------
    // Compare tasks
    // --------------------
    task automatic stopRun();
        $display("Simulation FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic mismatch(input string name, input logic [wbPkg::dataWidth-1:0] got, exp);
        $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        stopRun();
    endtask

    task automatic checkData(input string name, input logic [wbPkg::dataWidth-1:0] got, exp);
        if (got !== exp) mismatch(name, got, exp);
    endtask

    task automatic checkId(input string name, input logic [wbPkg::idWidth-1:0] got, exp);
        if (got !== exp) mismatch(name, wbPkg::dataWidth'(got), wbPkg::dataWidth'(exp));
    endtask

    task automatic checkUser(input string name, input logic [wbPkg::userWidth-1:0] got, exp);
        if (got !== exp) mismatch(name, wbPkg::dataWidth'(got), wbPkg::dataWidth'(exp));
    endtask

    task automatic checkWindow(input string name, input logic [wbPkg::windowWidth-1:0] got, exp);
        if (got !== exp) mismatch(name, wbPkg::dataWidth'(got), wbPkg::dataWidth'(exp));
    endtask

    task automatic checkBit(input string name, input logic got, exp);
        if (got !== exp) mismatch(name, wbPkg::dataWidth'(got), wbPkg::dataWidth'(exp));
    endtask

    function automatic int lowestFree();
        for (int s = 0; s < wbPkg::bufferDepth; s++) begin
            if (!slotUsed[s]) return s;
        end
        return -1;
    endfunction

    // Lowest buffered entry with the row's ID and user
    function automatic int matchSlot(input int r);
        for (int s = 0; s < wbPkg::bufferDepth; s++) begin
            if (slotUsed[s] && rowId[slotRow[s]] == rowId[r]
                && rowUser[slotRow[s]] == rowUser[r])
                return s;
        end
        return -1;
    endfunction

    // --------------------
    // Burst tasks
    // --------------------
    task automatic writeBurst(input int r, input bit cancel);
        int slot;
        bit ackRdy;
        bit last;
        slot = lowestFree();
        for (int b = 0; b < wbPkg::burstLength; b++) begin
            ackRdy = ($urandom % 2) == 1;
            last   = (b == wbPkg::burstLength - 1);
            @(posedge clk);
            writeDataValid    <= 1'b1;
            writeData         <= rowBase[r] + wbPkg::dataWidth'(b);   // Beat index in low bits
            writeDataID       <= rowId[r];
            writeDataUser     <= rowUser[r];
            writeDataStrb     <= rowStrb[r];
            writeDataLast     <= last;
            writeDataACKReady <= ackRdy;
            writeModeACK      <= cancel && last;     // Same-cycle retire cancels the add
            @(negedge clk);
            checkBit("writeBufferFull", writeBufferFull, 1'b0);
            checkBit("writeDataACKValid", writeDataACKValid, ackRdy && last);
            if (last) begin
                checkId("writeDataACKID", writeDataACKID, rowId[r]);
                checkUser("writeDataACKUser", writeDataACKUser, rowUser[r]);
            end
        end
        @(posedge clk);
        writeDataValid <= 1'b0;
        writeDataLast  <= 1'b0;
        writeModeACK   <= 1'b0;
        slotUsed[slot] = 1'b1;
        slotRow[slot]  = r;
        if (!cancel) expWindow++;
        @(negedge clk);
        checkWindow("writeRequestWindow", writeRequestWindow, expWindow);
    endtask

    task automatic streamBurst(input int r);
        int slot;
        int row;
        int beats;
        bit rdy;
        bit prevRdy;
        slot = matchSlot(r);
        if (slot < 0) begin
            $display("Issue for table row %0d matches no buffered burst", r);
            stopRun();
        end
        row = slotRow[slot];
        repeat (rowDelay[r]) @(posedge clk);
        @(posedge clk);
        writeBufferAllocID    <= rowId[r];
        writeBufferAllocUser  <= rowUser[r];
        writeBufferAllocValid <= 1'b1;            // Single-cycle issue ack
        beats   = 0;
        prevRdy = 1'b0;
        while (beats < wbPkg::burstLength) begin
            rdy = ($urandom % 100) < rowDuty[r];
            @(posedge clk);
            writeBufferAllocValid <= 1'b0;
            phyWriteModeFIFOReady <= rdy;
            @(negedge clk);
            // Valid follows the ready of the cycle before
            checkBit("readDataValid", readDataValid, prevRdy);
            if (prevRdy) begin
                checkData("readData", readData, rowBase[row] + wbPkg::dataWidth'(beats));
                checkBit("readDataStrb", readDataStrb, rowStrb[row][beats]);
                checkBit("readDataLast", readDataLast, beats == wbPkg::burstLength - 1);
                beats++;
            end
            prevRdy = rdy;
        end
        @(posedge clk);
        phyWriteModeFIFOReady <= 1'b0;
        writeModeACK          <= (expWindow != 0);   // PHY retires one write
        @(posedge clk);
        writeModeACK <= 1'b0;
        slotUsed[slot] = 1'b0;
        if (expWindow != 0) expWindow--;
        @(negedge clk);
        checkWindow("writeRequestWindow", writeRequestWindow, expWindow);
        checkBit("writeBufferFull", writeBufferFull, 1'b0);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        void'($urandom(seed));
        expWindow = '0;
        rst = 1'b0;
        writeData = '0;
        writeDataUser = '0;
        writeDataID = '0;
        writeDataStrb = '0;
        writeDataLast = 1'b0;
        writeDataValid = 1'b0;
        writeDataACKReady = 1'b0;
        writeBufferAllocID = '0;
        writeBufferAllocUser = '0;
        writeBufferAllocValid = 1'b0;
        phyWriteModeFIFOReady = 1'b0;
        writeModeACK = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        checkBit("writeBufferFull", writeBufferFull, 1'b0);
        checkBit("readDataValid", readDataValid, 1'b0);
        checkWindow("writeRequestWindow", writeRequestWindow, '0);
        // Fill all entries, last burst meets a retire in the same cycle
        for (int r = 0; r < rows; r++) writeBurst(r, r == rows - 1);
        checkBit("writeBufferFull", writeBufferFull, 1'b1);
        @(posedge clk);
        writeDataValid    <= 1'b1;                // Beat offered while full
        writeDataLast     <= 1'b1;
        writeDataACKReady <= 1'b1;
        @(negedge clk);
        checkBit("writeDataACKValid", writeDataACKValid, 1'b0);
        @(posedge clk);
        writeDataValid <= 1'b0;
        writeDataLast  <= 1'b0;
        @(negedge clk);
        checkWindow("writeRequestWindow", writeRequestWindow, expWindow);
        for (int i = 0; i < rows; i++) streamBurst(streamOrder[i]);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- sim.f
rtl/wbPkg.sv
rtl/wbFrontIntake.sv
rtl/wbDirectory.sv
rtl/wbDataStore.sv
rtl/wbBurstStreamer.sv
rtl/writeBufferCtrl.sv
verif/writeBufferCtrl_sva.sv
verif/tb_writeBufferCtrl.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_writeBufferCtrl \
    -f sim.f -o simv > sim.log 2>&1 &&
    ./obj_dir/simv >> sim.log 2>&1 ||
    echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
